/* Makefile */
# Verilator build and run for the SIMD multiplier testbench

VERILATOR ?= verilator
TOP       ?= simd_mult_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/10ps
RUN_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(wildcard verilog/*.sv verilog/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "\*\*\* PASSED \*\*\*" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
+incdir+verilog
verilog/mult_pkg.sv
verilog/mulh_seq.sv
verilog/short_mac.sv
verilog/dot_mac.sv
verilog/int_mac_mux.sv
verilog/simd_mult.sv
sim/tb_clock.sv
sim/simd_mult_assert.sv
sim/simd_mult_tb.sv

/* sim/simd_mult_assert.sv */
// Protocol assertions for the upper-half multiply sequencer
`timescale 1ns/10ps

module simd_mult_assert (
  input logic                  clk,
  input logic                  rst_n,
  input mult_pkg::mulh_state_e state_i,
  input logic                  carry_i,
  input logic                  ex_ready_i,
  input logic                  ready_i,
  input logic                  multicycle_i
);

  import mult_pkg::*;

  int fail_count = 0;

  ready_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == IDLE) |-> ready_i)
  else begin
    fail_count++;
    $error("ready_o is low while the sequencer is idle");
  end

  busy_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
    multicycle_i |-> !ready_i)
  else begin
    fail_count++;
    $error("ready_o is high during a working step");
  end

  // Consumer stall keeps the finished result in place
  finish_holds: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == FINISH && !ex_ready_i) |=> (state_i == FINISH))
  else begin
    fail_count++;
    $error("sequencer left FINISH while ex_ready_i was low");
  end

  carry_clear_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == IDLE) |-> !carry_i)
  else begin
    fail_count++;
    $error("carry register is set while the sequencer is idle");
  end

endmodule

bind mulh_seq simd_mult_assert u_seq_assert (
  .clk          (clk),
  .rst_n        (rst_n),
  .state_i      (state_q),
  .carry_i      (carry_q),
  .ex_ready_i   (ex_ready_i),
  .ready_i      (ready_o),
  .multicycle_i (multicycle_o)
);

/* sim/simd_mult_tb.sv */
// Directed self-checking testbench for the SIMD multiplier
`timescale 1ns/10ps

module simd_mult_tb;

  import mult_pkg::*;

  localparam int CLK_PERIOD      = 4;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 40;
  localparam int MULH_WAIT       = 12;

  logic      clk;
  logic      rst_n;
  mult_req_t req;
  logic      enable;
  logic      ex_ready;
  word_t     result;
  logic      ready;
  logic      multicycle;

  integer seed;
  string  cur_test;
  int     checks;
  int     errors;
  int     test_errors;
  int     tests_failed;

  tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) u_clock (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  simd_mult dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_i        (req),
    .enable_i     (enable),
    .ex_ready_i   (ex_ready),
    .result_o     (result),
    .ready_o      (ready),
    .multicycle_o (multicycle)
  );

  ////////////////////
  // Reference rules
  ////////////////////

  function automatic word_t random_word();
    return word_t'($random(seed));
  endfunction

  // Zero or sign extension of one lane of the given width
  function automatic longint extend_lane(logic [15:0] v, int width, logic is_signed);
    longint x;
    x = longint'(v);
    if (is_signed && v[width-1]) begin
      x = x - (longint'(1) << width);
    end
    return x;
  endfunction

  function automatic word_t short_mul_result(mult_req_t r);
    logic [15:0]        ha;
    logic [15:0]        hb;
    longint             sum;
    logic signed [32:0] sum33;
    logic [32:0]        shifted;
    ha  = r.short_subword ? r.op_a[31:16] : r.op_a[15:0];
    hb  = r.short_subword ? r.op_b[31:16] : r.op_b[15:0];
    sum = extend_lane(ha, 16, r.short_signed[0]) * extend_lane(hb, 16, r.short_signed[1]);
    sum = sum + longint'($signed(r.op_c));
    if (r.operator == MUL_IR && r.imm != 0) begin
      sum = sum + (longint'(1) << (r.imm - 1));
    end
    // Keep 33 bits, then shift with sign fill only for a signed a
    sum33 = sum[32:0];
    if (r.short_signed[0]) begin
      shifted = sum33 >>> r.imm;
    end else begin
      shifted = sum33 >> r.imm;
    end
    return shifted[31:0];
  endfunction

  function automatic word_t dot_product_sum(mult_req_t r, int lane_w);
    longint      acc;
    logic [15:0] la;
    logic [15:0] lb;
    acc = longint'(r.op_c);
    for (int i = 0; i < 32 / lane_w; i++) begin
      if (lane_w == 8) begin
        la = {8'b0, r.op_a[i*8 +: 8]};
        lb = {8'b0, r.op_b[i*8 +: 8]};
      end else begin
        la = r.op_a[i*16 +: 16];
        lb = r.op_b[i*16 +: 16];
      end
      acc = acc + extend_lane(la, lane_w, r.dot_signed[0]) *
                  extend_lane(lb, lane_w, r.dot_signed[1]);
    end
    return acc[31:0];
  endfunction

  function automatic word_t upper_product(word_t a, word_t b, sign_sel_t s);
    logic signed [63:0] ea;
    logic signed [63:0] eb;
    logic signed [63:0] p;
    ea = s[0] ? {{32{a[31]}}, a} : {32'b0, a};
    eb = s[1] ? {{32{b[31]}}, b} : {32'b0, b};
    p  = ea * eb;
    return p[63:32];
  endfunction

  ////////////////////
  // Compare and drive
  ////////////////////

  task automatic check_word(input string what, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("Error %s %s: expected %h, actual %h", cur_test, what, expected, actual);
    end
  endtask

  task automatic check_bit(input string what, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("Error %s %s: expected %b, actual %b", cur_test, what, expected, actual);
    end
  endtask

  task automatic note_failure(input string msg);
    errors++;
    test_errors++;
    $display("%s: %s", cur_test, msg);
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("%-18s finished with %0d errors", cur_test, test_errors);
  endtask

  // Drive on a falling edge, sample before the next rising edge
  task automatic apply_request(input mult_req_t r);
    @(negedge clk);
    req = r;
    #(CLK_PERIOD / 4);
  endtask

  // Start an upper-half multiply and wait for ready_o with a bound
  task automatic run_mulh(input word_t a, input word_t b, input sign_sel_t s,
                          output word_t res, output int busy, output int edges);
    mult_req_t r;
    int        waited;
    r              = '0;
    r.operator     = MUL_H;
    r.short_signed = s;
    r.op_a         = a;
    r.op_b         = b;
    r.op_c         = random_word();
    @(negedge clk);
    req    = r;
    enable = 1'b1;
    @(negedge clk);
    enable = 1'b0;
    busy   = 0;
    waited = 0;
    while (!ready && waited < MULH_WAIT) begin
      if (multicycle) begin
        busy++;
      end
      @(negedge clk);
      waited++;
    end
    if (!ready) begin
      note_failure("ready_o never rose after starting the upper-half multiply");
    end
    edges = waited + 1;
    res   = result;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_mac32();
    mult_req_t r;
    start_test("test_mac32");
    for (int i = 0; i < 4; i++) begin
      r          = '0;
      r.op_a     = random_word();
      r.op_b     = random_word();
      r.op_c     = random_word();
      r.operator = MUL_MAC32;
      apply_request(r);
      check_word("mac32", r.op_c + r.op_a * r.op_b, result);
      check_bit("mac32 ready", 1'b1, ready);
      r.operator = MUL_MSU32;
      apply_request(r);
      check_word("msu32", r.op_c - r.op_a * r.op_b, result);
      check_bit("msu32 ready", 1'b1, ready);
    end
    finish_test();
  endtask

  task automatic test_short_mul();
    mult_req_t r;
    word_t     fields;
    start_test("test_short_mul");
    for (int i = 0; i < 8; i++) begin
      r                = '0;
      fields           = random_word();
      r.operator       = (i % 2 == 1) ? MUL_IR : MUL_I;
      r.short_subword  = fields[0];
      r.short_signed   = fields[2:1];
      r.imm            = (i == 1) ? imm_t'(0) : fields[7:3];
      r.op_a           = random_word();
      r.op_b           = random_word();
      r.op_c           = random_word();
      apply_request(r);
      check_word(r.operator.name(), short_mul_result(r), result);
    end
    finish_test();
  endtask

  task automatic test_dot();
    mult_req_t r;
    start_test("test_dot");
    for (int s = 0; s < 4; s++) begin
      for (int v = 0; v < 2; v++) begin
        r            = '0;
        r.dot_signed = sign_sel_t'(s);
        r.op_a       = (v == 0) ? random_word() : 32'h80ff_7f80;
        r.op_b       = (v == 0) ? random_word() : 32'hff80_80ff;
        r.op_c       = random_word();
        r.operator   = MUL_DOT8;
        apply_request(r);
        check_word("dot8", dot_product_sum(r, 8), result);
        r.operator = MUL_DOT16;
        apply_request(r);
        check_word("dot16", dot_product_sum(r, 16), result);
      end
    end
    finish_test();
  endtask

  task automatic test_mulh();
    sign_sel_t modes[3];
    word_t     a_val[4];
    word_t     b_val[4];
    word_t     res;
    int        busy;
    int        edges;
    start_test("test_mulh");
    modes[0] = 2'b11;
    modes[1] = 2'b01;
    modes[2] = 2'b00;
    a_val[1] = 32'h8000_0000;
    b_val[1] = 32'h8000_0000;
    a_val[2] = 32'h8000_0000;
    b_val[2] = 32'hffff_ffff;
    a_val[3] = 32'hffff_ffff;
    b_val[3] = 32'hffff_ffff;
    for (int m = 0; m < 3; m++) begin
      a_val[0] = random_word();
      b_val[0] = random_word();
      for (int k = 0; k < 4; k++) begin
        run_mulh(a_val[k], b_val[k], modes[m], res, busy, edges);
        check_word("busy cycles", 32'd3, word_t'(busy));
        check_word("finish edge", 32'd4, word_t'(edges));
        check_word("upper result", upper_product(a_val[k], b_val[k], modes[m]), res);
      end
    end
    finish_test();
  endtask

  task automatic test_backpressure();
    mult_req_t r;
    word_t     a;
    word_t     b;
    word_t     res;
    word_t     fields;
    int        busy;
    int        edges;
    int        hold;
    start_test("test_backpressure");
    a = random_word();
    b = random_word();
    @(negedge clk);
    ex_ready = 1'b0;
    run_mulh(a, b, 2'b11, res, busy, edges);
    check_word("upper result", upper_product(a, b, 2'b11), res);
    hold = 2 + int'($random(seed) & 7);
    repeat (hold) begin
      @(negedge clk);
      check_word("held result", upper_product(a, b, 2'b11), result);
      check_bit("held ready", 1'b1, ready);
      check_bit("held multicycle", 1'b0, multicycle);
    end
    ex_ready = 1'b1;
    @(negedge clk);
    check_bit("ready after release", 1'b1, ready);
    // A short multiply right after the release must see no stale carry
    r               = '0;
    fields          = random_word();
    r.operator      = MUL_I;
    r.short_subword = fields[0];
    r.short_signed  = fields[2:1];
    r.imm           = fields[7:3];
    r.op_a          = random_word();
    r.op_b          = random_word();
    r.op_c          = random_word();
    apply_request(r);
    check_word("mul_i after release", short_mul_result(r), result);
    finish_test();
  endtask

  ////////////////////
  // Run control
  ////////////////////

  initial begin : watchdog
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("Watchdog: the run did not finish within %0d ns",
             NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : main
    int assert_fails;
    seed         = 32'hc22d6845;
    req          = '0;
    enable       = 1'b0;
    ex_ready     = 1'b1;
    checks       = 0;
    errors       = 0;
    tests_failed = 0;
    @(posedge rst_n);
    test_mac32();
    test_short_mul();
    test_dot();
    test_mulh();
    test_backpressure();
    assert_fails = dut0.u_mulh_seq.u_seq_assert.fail_count;
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             NUM_TESTS, tests_failed, checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* sim/tb_clock.sv */
// Testbench clock and power-on reset generator
`timescale 1ns/10ps

module tb_clock #(
  parameter int PERIOD       = 4,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset is released on a falling edge, away from the active edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* verilog/dot_mac.sv */
// SIMD dot products over byte and halfword lanes, accumulated onto op_c
`timescale 1ns/10ps
`include "mult_settings.svh"

module dot_mac (
  input  mult_pkg::mult_req_t req_i,
  output mult_pkg::word_t     dot8_o,
  output mult_pkg::word_t     dot16_o
);

  import mult_pkg::*;

  localparam int DW = `MULT_DATA_W;
  localparam int BW = `MULT_BYTE_W;
  localparam int HW = `MULT_HALF_W;
  localparam int BN = DW / BW;
  localparam int HN = DW / HW;

  logic [BN-1:0][BW:0]     byte_a;
  logic [BN-1:0][BW:0]     byte_b;
  logic [BN-1:0][2*BW+1:0] byte_mul;
  logic [HN-1:0][HW:0]     half_a;
  logic [HN-1:0][HW:0]     half_b;
  logic [HN-1:0][2*HW+1:0] half_mul;

  ////////////////////
  // Byte lanes
  ////////////////////

  for (genvar i = 0; i < BN; i++) begin : g_byte
    assign byte_a[i]   = {req_i.dot_signed[0] & req_i.op_a[i*BW+BW-1], req_i.op_a[i*BW +: BW]};
    assign byte_b[i]   = {req_i.dot_signed[1] & req_i.op_b[i*BW+BW-1], req_i.op_b[i*BW +: BW]};
    assign byte_mul[i] = $signed(byte_a[i]) * $signed(byte_b[i]);
  end

  ////////////////////
  // Halfword lanes
  ////////////////////

  for (genvar i = 0; i < HN; i++) begin : g_half
    assign half_a[i]   = {req_i.dot_signed[0] & req_i.op_a[i*HW+HW-1], req_i.op_a[i*HW +: HW]};
    assign half_b[i]   = {req_i.dot_signed[1] & req_i.op_b[i*HW+HW-1], req_i.op_b[i*HW +: HW]};
    assign half_mul[i] = $signed(half_a[i]) * $signed(half_b[i]);
  end

  // Lane sums wrap at 32 bits
  always_comb begin
    logic signed [DW-1:0] sum8;
    logic signed [DW-1:0] sum16;

    sum8  = $signed(req_i.op_c);
    sum16 = $signed(req_i.op_c);
    for (int i = 0; i < BN; i++) begin
      sum8 = sum8 + $signed(byte_mul[i]);
    end
    for (int i = 0; i < HN; i++) begin
      sum16 = sum16 + $signed(half_mul[i][DW-1:0]);
    end
    dot8_o  = sum8;
    dot16_o = sum16;
  end

endmodule

/* verilog/int_mac_mux.sv */
// 32-bit multiply-accumulate/subtract and final result select by operator
`timescale 1ns/10ps
`include "mult_settings.svh"

module int_mac_mux (
  input  mult_pkg::mult_req_t req_i,
  input  mult_pkg::word_t     short_i,
  input  mult_pkg::word_t     dot8_i,
  input  mult_pkg::word_t     dot16_i,
  output mult_pkg::word_t     result_o
);

  import mult_pkg::*;

  logic  is_msu;
  word_t op_a_msu;
  word_t op_b_msu;
  word_t int_res;

  // c - a*b  ==  c + (~a)*b + b
  assign is_msu   = (req_i.operator == MUL_MSU32);
  assign op_a_msu = req_i.op_a ^ {`MULT_DATA_W{is_msu}};
  assign op_b_msu = req_i.op_b & {`MULT_DATA_W{is_msu}};

  assign int_res = req_i.op_c + op_b_msu + op_a_msu * req_i.op_b;

  ////////////////////
  // Result select
  ////////////////////

  always_comb begin
    result_o = '0;
    case (req_i.operator)
      MUL_MAC32, MUL_MSU32: result_o = int_res;
      MUL_I, MUL_IR, MUL_H: result_o = short_i;
      MUL_DOT8:             result_o = dot8_i;
      MUL_DOT16:            result_o = dot16_i;
      default:              result_o = '0;
    endcase
  end

endmodule

/* verilog/mulh_seq.sv */
// Upper-half multiply sequencer stepping the short multiplier through four partial products
`timescale 1ns/10ps
`include "mult_settings.svh"

module mulh_seq (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   enable_i,
  input  mult_pkg::mult_req_t    req_i,
  input  logic                   ex_ready_i,
  input  logic                   mac_carry_i,
  input  mult_pkg::word_t        short_res_i,
  output mult_pkg::short_ctrl_t  ctrl_o,
  output logic                   ready_o,
  output logic                   multicycle_o
);

  import mult_pkg::*;

  mulh_state_e state_q;
  mulh_state_e state_d;
  logic        carry_q;
  word_t       acc_q;
  logic        active;
  logic        step_busy;
  logic        carry_load;
  logic        carry_clr;
  imm_t        step_imm;
  logic [1:0]  step_subword;
  sign_sel_t   step_signs;
  logic        step_arith;

  ////////////////////
  // Step decode
  ////////////////////

  always_comb begin
    state_d      = state_q;
    step_imm     = '0;
    step_subword = 2'b00;
    step_signs   = 2'b00;
    step_arith   = 1'b0;
    step_busy    = 1'b0;
    carry_load   = 1'b0;
    carry_clr    = 1'b0;

    case (state_q)
      IDLE: begin
        if (enable_i && (req_i.operator == MUL_H)) begin
          state_d = STEP0;
        end
      end

      // AL*BL is always unsigned and never overflows
      STEP0: begin
        step_imm  = imm_t'(`MULT_MULH_SHIFT);
        step_busy = 1'b1;
        state_d   = STEP1;
      end

      // AL*BH signed only if b is, keep the 33rd bit as carry
      STEP1: begin
        step_signs   = {req_i.short_signed[1], 1'b0};
        step_subword = 2'b10;
        step_arith   = 1'b1;
        step_busy    = 1'b1;
        carry_load   = 1'b1;
        state_d      = STEP2;
      end

      // AH*BL signed only if a is; upper bits shift back in, so no carry kept
      STEP2: begin
        step_signs   = {1'b0, req_i.short_signed[0]};
        step_subword = 2'b01;
        step_imm     = imm_t'(`MULT_MULH_SHIFT);
        step_arith   = 1'b1;
        step_busy    = 1'b1;
        carry_clr    = 1'b1;
        state_d      = FINISH;
      end

      FINISH: begin
        step_signs   = req_i.short_signed;
        step_subword = 2'b11;
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (carry_load) begin
        carry_q <= mac_carry_i;
      end else if (carry_clr || ex_ready_i) begin
        carry_q <= 1'b0;
      end
    end
  end

  // Partial sum fed back as accumulator, starts from zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (state_q == IDLE) begin
      acc_q <= '0;
    end else if (step_busy) begin
      acc_q <= short_res_i;
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign active = (state_q != IDLE);

  // Outside a sequence the MUL_I fields of the request go straight through
  always_comb begin
    ctrl_o.active      = active;
    ctrl_o.subword     = active ? step_subword : {2{req_i.short_subword}};
    ctrl_o.signs       = active ? step_signs   : req_i.short_signed;
    ctrl_o.shift_arith = active ? step_arith   : req_i.short_signed[0];
    ctrl_o.imm         = active ? step_imm     : req_i.imm;
    ctrl_o.carry       = carry_q;
    ctrl_o.acc         = acc_q;
  end

  assign ready_o      = (state_q == IDLE) || (state_q == FINISH);
  assign multicycle_o = step_busy;

endmodule

/* verilog/mult_pkg.sv */
// Multiplier package: vector types, operator and sequencer enums, request structs
package mult_pkg;

`include "mult_settings.svh"

  typedef logic [`MULT_DATA_W-1:0] word_t;
  typedef logic [`MULT_HALF_W-1:0] half_t;
  typedef logic [`MULT_IMM_W-1:0]  imm_t;

  // Bit 0 marks op_a as signed, bit 1 marks op_b as signed
  typedef logic [1:0] sign_sel_t;

  typedef enum logic [3:0] {
    MUL_MAC32 = 4'h0,
    MUL_MSU32 = 4'h1,
    MUL_I     = 4'h2,
    MUL_IR    = 4'h3,
    MUL_DOT8  = 4'h4,
    MUL_DOT16 = 4'h5,
    MUL_H     = 4'h6
  } mult_op_e;

  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    STEP0  = 3'd1,
    STEP1  = 3'd2,
    STEP2  = 3'd3,
    FINISH = 3'd4
  } mulh_state_e;

  typedef struct packed {
    mult_op_e  operator;
    logic      short_subword;
    sign_sel_t short_signed;
    sign_sel_t dot_signed;
    imm_t      imm;
    word_t     op_a;
    word_t     op_b;
    word_t     op_c;
  } mult_req_t;

  // Sequencer controls for the short multiplier
  typedef struct packed {
    logic       active;
    logic [1:0] subword;
    sign_sel_t  signs;
    logic       shift_arith;
    imm_t       imm;
    logic       carry;
    word_t      acc;
  } short_ctrl_t;

endpackage

/* verilog/mult_settings.svh */
// Multiplier settings: operand widths and shift constants shared by all blocks
`ifndef MULT_SETTINGS_SVH
`define MULT_SETTINGS_SVH

// Full word width of operands and result
`define MULT_DATA_W 32

// Subword width for short multiply and halfword dot lanes
`define MULT_HALF_W 16

// Byte lane width for the 4-lane dot product
`define MULT_BYTE_W 8

// Width of the shift immediate
`define MULT_IMM_W 5

// Shift applied between upper-half multiply steps
`define MULT_MULH_SHIFT 16

`endif

/* verilog/short_mac.sv */
// Subword multiply-accumulate with optional rounding and arithmetic right shift
`timescale 1ns/10ps
`include "mult_settings.svh"

module short_mac (
  input  mult_pkg::mult_req_t   req_i,
  input  mult_pkg::short_ctrl_t ctrl_i,
  output mult_pkg::word_t       result_o,
  output logic                  mac_carry_o
);

  import mult_pkg::*;

  localparam int DW = `MULT_DATA_W;
  localparam int HW = `MULT_HALF_W;

  half_t         a_half;
  half_t         b_half;
  logic [HW:0]   op_a_ext;
  logic [HW:0]   op_b_ext;
  logic [DW:0]   op_c_ext;
  logic [DW+1:0] mul;
  logic [DW+1:0] mac;
  word_t         round_step;
  word_t         round_val;
  logic          shift_top;
  logic [DW+1:0] shift_src;
  logic [DW+1:0] shifted;

  ////////////////////
  // Operands
  ////////////////////

  // Subword select, then extend by the sign flags
  assign a_half = ctrl_i.subword[0] ? req_i.op_a[DW-1:HW] : req_i.op_a[HW-1:0];
  assign b_half = ctrl_i.subword[1] ? req_i.op_b[DW-1:HW] : req_i.op_b[HW-1:0];

  assign op_a_ext = {ctrl_i.signs[0] & a_half[HW-1], a_half};
  assign op_b_ext = {ctrl_i.signs[1] & b_half[HW-1], b_half};

  // During MUL_H the partial sum and its carry replace op_c
  assign op_c_ext = ctrl_i.active ? {ctrl_i.carry, ctrl_i.acc}
                                  : {req_i.op_c[DW-1], req_i.op_c};

  ////////////////////
  // Multiply-add
  ////////////////////

  // Half of one shift step for MUL_IR
  assign round_step = word_t'(1) << ctrl_i.imm;
  assign round_val  = (req_i.operator == MUL_IR) ? (round_step >> 1) : '0;

  assign mul = $signed(op_a_ext) * $signed(op_b_ext);
  assign mac = $signed(op_c_ext) + $signed(mul) + $signed({1'b0, round_val});

  ////////////////////
  // Shift
  ////////////////////

  // 34-bit sign only matters mid-sequence, otherwise bit 32 is the top
  assign shift_top = ctrl_i.active ? mac[DW+1] : mac[DW];
  assign shift_src = {ctrl_i.shift_arith & shift_top, mac[DW:0]};
  assign shifted   = $signed(shift_src) >>> ctrl_i.imm;

  assign result_o    = shifted[DW-1:0];
  assign mac_carry_o = mac[DW];

endmodule

/* verilog/simd_mult.sv */
// SIMD multiplier top: sequencer, short MAC, dot unit and result mux
`timescale 1ns/10ps

module simd_mult (
  input  logic                clk,
  input  logic                rst_n,
  input  mult_pkg::mult_req_t req_i,
  input  logic                enable_i,
  input  logic                ex_ready_i,
  output mult_pkg::word_t     result_o,
  output logic                ready_o,
  output logic                multicycle_o
);

  import mult_pkg::*;

  short_ctrl_t short_ctrl;
  word_t       short_res;
  word_t       dot8_res;
  word_t       dot16_res;
  logic        mac_carry;

  mulh_seq u_mulh_seq (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (enable_i),
    .req_i        (req_i),
    .ex_ready_i   (ex_ready_i),
    .mac_carry_i  (mac_carry),
    .short_res_i  (short_res),
    .ctrl_o       (short_ctrl),
    .ready_o      (ready_o),
    .multicycle_o (multicycle_o)
  );

  short_mac u_short_mac (
    .req_i       (req_i),
    .ctrl_i      (short_ctrl),
    .result_o    (short_res),
    .mac_carry_o (mac_carry)
  );

  dot_mac u_dot_mac (
    .req_i   (req_i),
    .dot8_o  (dot8_res),
    .dot16_o (dot16_res)
  );

  int_mac_mux u_int_mac_mux (
    .req_i    (req_i),
    .short_i  (short_res),
    .dot8_i   (dot8_res),
    .dot16_i  (dot16_res),
    .result_o (result_o)
  );

endmodule
